// ==== include/adpll_defines.svh ====
`ifndef ADPLL_DEFINES_SVH
`define ADPLL_DEFINES_SVH

// number of reference/loop channel pairs
`define ADPLL_NUM_CH 4

// phase accumulator and tuning word width
`define ADPLL_ACC_W 12

// signed phase error width, saturates at +/-127
`define ADPLL_ERR_W 8

// free-running oscillator increment
`define ADPLL_BIAS 154

// loop gains as arithmetic right shifts
`define ADPLL_KP_SHIFT 1
`define ADPLL_KI_SHIFT 4
`define ADPLL_INT_W 16

// lock detector
`define ADPLL_LOCK_TOL 3
`define ADPLL_LOCK_CNT 16

// display
`define ADPLL_SCAN_BITS 4
`define ADPLL_SEL_W 2

`endif

// ==== verilog/adpll_pkg.sv ====
`include "adpll_defines.svh"

package adpll_pkg;

    typedef logic [`ADPLL_ACC_W-1:0] tune_word_t;          // accumulator increment
    typedef logic signed [`ADPLL_ERR_W-1:0] phase_err_t;   // + means reference leads
    typedef logic signed [`ADPLL_ACC_W-1:0] freq_corr_t;   // added to the bias
    typedef logic [`ADPLL_SEL_W-1:0] ch_sel_t;
    typedef logic [7:0] seg_t;                             // active low, dp in bit 7
    typedef logic [7:0] digit_t;                           // active low, lower four used

    // per-channel status seen by the display
    typedef struct packed {
        phase_err_t err;
        logic       err_valid;    // one-cycle strobe
        logic       locked;
    } ch_status_t;

    typedef enum logic [1:0] {
        IDLE,
        REF_LEAD,
        GEN_LEAD
    } pd_state_e;

endpackage

// ==== verilog/ref_osc_bank.sv ====
`include "adpll_defines.svh"

module ref_osc_bank (
    input  logic                                       fpga_clk_i,
    input  logic                                       reset_i,
    input  adpll_pkg::tune_word_t [`ADPLL_NUM_CH-1:0]  ref_k_i,
    output logic [`ADPLL_NUM_CH-1:0]                   ref_clk_o
);

    adpll_pkg::tune_word_t [`ADPLL_NUM_CH-1:0] acc_q;     // one phase accumulator per channel

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            acc_q <= '0;
        end else begin
            for (int ch = 0; ch < `ADPLL_NUM_CH; ch++) begin
                acc_q[ch] <= acc_q[ch] + ref_k_i[ch];     // wraps naturally
            end
        end
    end

    // the reference clock is the accumulator msb, duty close to 50%
    always_comb begin
        for (int ch = 0; ch < `ADPLL_NUM_CH; ch++) begin
            ref_clk_o[ch] = acc_q[ch][`ADPLL_ACC_W-1];
        end
    end

endmodule

// ==== verilog/phase_detector.sv ====
`include "adpll_defines.svh"

module phase_detector (
    input  logic                   fpga_clk_i,
    input  logic                   reset_i,
    input  logic                   ref_clk_i,
    input  logic                   gen_clk_i,
    output adpll_pkg::phase_err_t  err_o,
    output logic                   err_valid_o
);

    localparam int unsigned CNT_W = `ADPLL_ERR_W - 1;

    logic                  ref_prev_q;
    logic                  gen_prev_q;
    logic                  ref_rise;
    logic                  gen_rise;
    adpll_pkg::pd_state_e  state_q;
    logic [CNT_W-1:0]      cnt_q;       // cycles since the leading edge
    adpll_pkg::phase_err_t err_q;
    logic                  valid_q;

    assign ref_rise = ref_clk_i & ~ref_prev_q;
    assign gen_rise = gen_clk_i & ~gen_prev_q;

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            ref_prev_q <= 1'b0;
            gen_prev_q <= 1'b0;
            state_q    <= adpll_pkg::IDLE;
            cnt_q      <= '0;
            err_q      <= '0;
            valid_q    <= 1'b0;
        end else begin
            ref_prev_q <= ref_clk_i;
            gen_prev_q <= gen_clk_i;
            valid_q    <= 1'b0;                                 // strobe by default
            case (state_q)
                adpll_pkg::IDLE: begin
                    if (ref_rise && gen_rise) begin
                        err_q   <= '0;                          // edges coincide
                        valid_q <= 1'b1;
                    end else if (ref_rise) begin
                        state_q <= adpll_pkg::REF_LEAD;
                        cnt_q   <= CNT_W'(1);
                    end else if (gen_rise) begin
                        state_q <= adpll_pkg::GEN_LEAD;
                        cnt_q   <= CNT_W'(1);
                    end
                end
                adpll_pkg::REF_LEAD: begin
                    if (gen_rise) begin
                        err_q   <= adpll_pkg::phase_err_t'(cnt_q);
                        valid_q <= 1'b1;
                        state_q <= adpll_pkg::IDLE;
                    end else if (cnt_q != '1) begin
                        cnt_q <= cnt_q + 1'b1;                  // saturates at 127
                    end
                end
                adpll_pkg::GEN_LEAD: begin
                    if (ref_rise) begin
                        err_q   <= -adpll_pkg::phase_err_t'(cnt_q);
                        valid_q <= 1'b1;
                        state_q <= adpll_pkg::IDLE;
                    end else if (cnt_q != '1) begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= adpll_pkg::IDLE;
            endcase
        end
    end

    assign err_o       = err_q;
    assign err_valid_o = valid_q;

endmodule

// ==== verilog/loop_filter.sv ====
`include "adpll_defines.svh"

module loop_filter (
    input  logic                   fpga_clk_i,
    input  logic                   reset_i,
    input  adpll_pkg::phase_err_t  err_i,
    input  logic                   err_valid_i,
    output adpll_pkg::freq_corr_t  corr_o
);

    localparam int unsigned INT_W = `ADPLL_INT_W;
    localparam int unsigned ACC_W = `ADPLL_ACC_W;

    logic signed [INT_W-1:0] integ_q;
    logic signed [INT_W:0]   integ_sum;    // one guard bit for overflow
    logic signed [INT_W-1:0] integ_next;
    logic signed [INT_W:0]   corr_sum;
    adpll_pkg::freq_corr_t   corr_next;
    adpll_pkg::freq_corr_t   corr_q;

    always_comb begin
        integ_sum = (INT_W+1)'(integ_q) + (INT_W+1)'(err_i);
        if (integ_sum[INT_W] != integ_sum[INT_W-1]) begin
            integ_next = integ_sum[INT_W] ? {1'b1, {(INT_W-1){1'b0}}}   // clamp at min
                                          : {1'b0, {(INT_W-1){1'b1}}};  // clamp at max
        end else begin
            integ_next = integ_sum[INT_W-1:0];
        end

        // proportional path plus scaled integrator
        corr_sum = (INT_W+1)'(err_i >>> `ADPLL_KP_SHIFT)
                 + (INT_W+1)'(integ_next >>> `ADPLL_KI_SHIFT);
        if (&corr_sum[INT_W:ACC_W-1] || ~|corr_sum[INT_W:ACC_W-1]) begin
            corr_next = corr_sum[ACC_W-1:0];
        end else begin
            corr_next = corr_sum[INT_W] ? {1'b1, {(ACC_W-1){1'b0}}}
                                        : {1'b0, {(ACC_W-1){1'b1}}};
        end
    end

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            integ_q <= '0;
            corr_q  <= '0;
        end else if (err_valid_i) begin   // filter only moves on detector strobes
            integ_q <= integ_next;
            corr_q  <= corr_next;
        end
    end

    assign corr_o = corr_q;

endmodule

// ==== verilog/adpll_channel.sv ====
`include "adpll_defines.svh"

module adpll_channel (
    input  logic                   fpga_clk_i,
    input  logic                   reset_i,
    input  logic                   ref_clk_i,
    output logic                   gen_clk_o,
    output adpll_pkg::ch_status_t  status_o
);

    localparam int unsigned LOCK_W = $clog2(`ADPLL_LOCK_CNT + 1);
    localparam adpll_pkg::phase_err_t TOL_P = adpll_pkg::phase_err_t'(`ADPLL_LOCK_TOL);
    localparam adpll_pkg::phase_err_t TOL_N = -TOL_P;

    adpll_pkg::phase_err_t pd_err;
    logic                  pd_valid;
    adpll_pkg::freq_corr_t corr;
    adpll_pkg::tune_word_t osc_q;        // dco phase accumulator
    logic                  in_tol;
    logic [LOCK_W-1:0]     lock_cnt_q;
    logic [LOCK_W-1:0]     lock_cnt_next;

    phase_detector phase_detector_inst (
        .fpga_clk_i  (fpga_clk_i),
        .reset_i     (reset_i),
        .ref_clk_i   (ref_clk_i),
        .gen_clk_i   (gen_clk_o),
        .err_o       (pd_err),
        .err_valid_o (pd_valid)
    );

    loop_filter loop_filter_inst (
        .fpga_clk_i  (fpga_clk_i),
        .reset_i     (reset_i),
        .err_i       (pd_err),
        .err_valid_i (pd_valid),
        .corr_o      (corr)
    );

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            osc_q      <= '0;
            lock_cnt_q <= '0;
        end else begin
            osc_q      <= osc_q + adpll_pkg::tune_word_t'(`ADPLL_BIAS) + corr;
            lock_cnt_q <= lock_cnt_next;
        end
    end

    assign gen_clk_o = osc_q[`ADPLL_ACC_W-1];

    // lock count includes the strobe in flight so locked lines up with err
    assign in_tol = (pd_err <= TOL_P) && (pd_err >= TOL_N);
    always_comb begin
        lock_cnt_next = lock_cnt_q;
        if (pd_valid) begin
            if (!in_tol) begin
                lock_cnt_next = '0;
            end else if (lock_cnt_q != LOCK_W'(`ADPLL_LOCK_CNT)) begin
                lock_cnt_next = lock_cnt_q + 1'b1;
            end
        end
    end

    assign status_o.err       = pd_err;
    assign status_o.err_valid = pd_valid;
    assign status_o.locked    = (lock_cnt_next == LOCK_W'(`ADPLL_LOCK_CNT));

endmodule

// ==== verilog/error_display.sv ====
`include "adpll_defines.svh"

module error_display (
    input  logic                                       fpga_clk_i,
    input  logic                                       reset_i,
    input  adpll_pkg::ch_sel_t                         sel_i,
    input  adpll_pkg::ch_status_t [`ADPLL_NUM_CH-1:0]  status_i,
    output adpll_pkg::phase_err_t                      error_o,
    output logic                                       locked_o,
    output adpll_pkg::seg_t                            segment_o,
    output adpll_pkg::digit_t                          digit_o
);

    localparam int unsigned ERR_W = `ADPLL_ERR_W;
    localparam int unsigned SCAN_W = `ADPLL_SCAN_BITS + 2;

    adpll_pkg::ch_sel_t    sel_q;
    adpll_pkg::ch_status_t sel_status;
    adpll_pkg::phase_err_t error_q;
    logic                  locked_q;
    logic [SCAN_W-1:0]     scan_q;     // top two bits pick the digit
    logic [1:0]            scan_idx;
    logic [ERR_W-1:0]      mag;

    // common anode font, segments a..g in bits 0..6
    function automatic adpll_pkg::seg_t hex_font(input logic [3:0] nib);
        case (nib)
            4'h0: hex_font = 8'hC0;
            4'h1: hex_font = 8'hF9;
            4'h2: hex_font = 8'hA4;
            4'h3: hex_font = 8'hB0;
            4'h4: hex_font = 8'h99;
            4'h5: hex_font = 8'h92;
            4'h6: hex_font = 8'h82;
            4'h7: hex_font = 8'hF8;
            4'h8: hex_font = 8'h80;
            4'h9: hex_font = 8'h90;
            4'hA: hex_font = 8'h88;
            4'hB: hex_font = 8'h83;
            4'hC: hex_font = 8'hC6;
            4'hD: hex_font = 8'hA1;
            4'hE: hex_font = 8'h86;
            default: hex_font = 8'h8E;
        endcase
    endfunction

    assign sel_status = status_i[sel_i];

    always_ff @(posedge fpga_clk_i) begin
        if (reset_i) begin
            sel_q    <= '0;
            error_q  <= '0;
            locked_q <= 1'b0;
            scan_q   <= '0;
        end else begin
            sel_q  <= sel_i;
            scan_q <= scan_q + 1'b1;
            if (sel_status.err_valid || (sel_i != sel_q)) begin
                error_q  <= sel_status.err;
                locked_q <= sel_status.locked;
            end
        end
    end

    assign scan_idx = scan_q[SCAN_W-1:SCAN_W-2];
    assign mag      = error_q[ERR_W-1] ? ERR_W'(-error_q) : ERR_W'(error_q);

    always_comb begin
        case (scan_idx)
            2'd0: segment_o = hex_font(mag[3:0]);
            2'd1: segment_o = hex_font(mag[7:4]);
            2'd2: segment_o = 8'hFF;                                  // blank
            default: segment_o = error_q[ERR_W-1] ? 8'hBF : 8'hFF;    // minus sign
        endcase
    end

    assign digit_o  = ~(adpll_pkg::digit_t'(1) << scan_idx);
    assign error_o  = error_q;
    assign locked_o = locked_q;

endmodule

// ==== verilog/adpll_bank_top.sv ====
`include "adpll_defines.svh"

module adpll_bank_top (
    input  logic                                       fpga_clk_i,
    input  logic                                       reset_i,
    input  adpll_pkg::tune_word_t [`ADPLL_NUM_CH-1:0]  ref_k_i,
    input  adpll_pkg::ch_sel_t                         sel_i,
    output logic [`ADPLL_NUM_CH-1:0]                   ref_clk_o,
    output logic [`ADPLL_NUM_CH-1:0]                   gen_clk_o,
    output adpll_pkg::phase_err_t                      error_o,
    output logic                                       locked_o,
    output adpll_pkg::seg_t                            segment_o,
    output adpll_pkg::digit_t                          digit_o
);

    adpll_pkg::ch_status_t [`ADPLL_NUM_CH-1:0] ch_status;

    ref_osc_bank ref_osc_bank_inst (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .ref_k_i    (ref_k_i),
        .ref_clk_o  (ref_clk_o)
    );

    for (genvar ch = 0; ch < `ADPLL_NUM_CH; ch++) begin : g_channel
        adpll_channel adpll_channel_inst (
            .fpga_clk_i (fpga_clk_i),
            .reset_i    (reset_i),
            .ref_clk_i  (ref_clk_o[ch]),    // each loop tracks its own reference
            .gen_clk_o  (gen_clk_o[ch]),
            .status_o   (ch_status[ch])
        );
    end

    error_display error_display_inst (
        .fpga_clk_i (fpga_clk_i),
        .reset_i    (reset_i),
        .sel_i      (sel_i),
        .status_i   (ch_status),
        .error_o    (error_o),
        .locked_o   (locked_o),
        .segment_o  (segment_o),
        .digit_o    (digit_o)
    );

endmodule

// ==== sim/adpll_bank_tb.sv ====
`include "adpll_defines.svh"

module adpll_bank_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NCH = `ADPLL_NUM_CH;
    localparam int MSB = `ADPLL_ACC_W - 1;
    localparam int ERR_MAX = (1 << (`ADPLL_ERR_W - 1)) - 1;
    localparam int SWEEP_CYC = 300;      // per selected channel
    localparam int SETTLE_CYC = 6000;
    localparam int WINDOW_CYC = 2000;
    localparam int LOCK_WAIT = 3000;
    localparam int FAR_WAIT = 2000;
    localparam int TIMEOUT_CYC = 16 + NCH * SWEEP_CYC + SETTLE_CYC + WINDOW_CYC
                               + NCH * LOCK_WAIT + FAR_WAIT + 1000;

    // lit segments g..a for hex digits 0..F
    localparam logic [6:0] HEX_LIT [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic                            fpga_clk;
    logic                            reset;
    adpll_pkg::tune_word_t [NCH-1:0] ref_k;
    adpll_pkg::ch_sel_t              sel;
    logic [NCH-1:0]                  ref_clk;
    logic [NCH-1:0]                  gen_clk;
    adpll_pkg::phase_err_t           error;
    logic                            locked;
    adpll_pkg::seg_t                 segment;
    adpll_pkg::digit_t               digit;

    bit [MSB:0] acc_m [NCH];      // reference accumulators
    int         pd_state [NCH];   // 0 idle, 1 reference leads, 2 generated leads
    int         pd_cnt [NCH];
    int         err_m [NCH];
    bit         valid_m [NCH];
    int         lock_m [NCH];
    bit         ref_prev [NCH];
    bit         gen_prev [NCH];
    bit         out_tol_seen [NCH];
    int         disp_err;
    bit         disp_lock;
    int         disp_sel;
    int         scan_m;
    bit [3:0]   digit_seen;
    int         cycles;

    adpll_bank_top adpll_bank_top_inst (
        .fpga_clk_i (fpga_clk),
        .reset_i    (reset),
        .ref_k_i    (ref_k),
        .sel_i      (sel),
        .ref_clk_o  (ref_clk),
        .gen_clk_o  (gen_clk),
        .error_o    (error),
        .locked_o   (locked),
        .segment_o  (segment),
        .digit_o    (digit)
    );

    always #20 fpga_clk = ~fpga_clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_equal(input logic signed [31:0] actual,
                               input logic signed [31:0] expected, input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error at %0d ns: %s is %0d, expected %0d",
                                        $time, what, actual, expected));
        end
    endtask

    function automatic adpll_pkg::tune_word_t near_bias_word();
        return adpll_pkg::tune_word_t'(`ADPLL_BIAS - 20 + int'($urandom % 41));
    endfunction

    // digit 0 low nibble, 1 high nibble, 2 blank, 3 sign
    function automatic logic [7:0] expected_segment(input int idx, input int err);
        int         mag;
        logic [6:0] lit;
        mag = (err < 0) ? -err : err;
        case (idx)
            0: lit = HEX_LIT[mag % 16];
            1: lit = HEX_LIT[(mag / 16) % 16];
            2: lit = 7'h00;
            default: lit = (err < 0) ? 7'h40 : 7'h00;
        endcase
        return {1'b1, ~lit};
    endfunction

    always @(posedge fpga_clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            stop_with_failure($sformatf("timeout: run did not finish in %0d cycles", cycles));
        end
    end

    // model steps to the next rising edge after outputs settle at the falling edge
    always @(negedge fpga_clk) begin
        int idx;
        int sel_now;
        bit r_rise;
        bit g_rise;
        idx = scan_m >> `ADPLL_SCAN_BITS;
        for (int ch = 0; ch < NCH; ch++) begin
            check_equal(ref_clk[ch], acc_m[ch][MSB], $sformatf("ref_clk_o[%0d]", ch));
        end
        check_equal(error, disp_err, "error_o");
        check_equal(locked, disp_lock, "locked_o");
        check_equal(digit, 8'hFF ^ (8'h01 << idx), "digit_o");
        check_equal(segment, expected_segment(idx, disp_err), "segment_o");
        for (int d = 0; d < 4; d++) begin
            if (digit == (8'hFF ^ (8'h01 << d))) begin
                digit_seen[d] = 1'b1;
            end
        end

        sel_now = int'(sel);
        if (reset) begin
            disp_err  = 0;
            disp_lock = 1'b0;
            disp_sel  = 0;
            scan_m    = 0;
        end else begin
            if (valid_m[sel_now] || sel_now != disp_sel) begin   // strobe or new selection
                disp_err  = err_m[sel_now];
                disp_lock = (lock_m[sel_now] == `ADPLL_LOCK_CNT);
            end
            disp_sel = sel_now;
            scan_m   = (scan_m + 1) % (4 << `ADPLL_SCAN_BITS);
        end

        for (int ch = 0; ch < NCH; ch++) begin
            acc_m[ch] = reset ? '0 : acc_m[ch] + ref_k[ch];
            r_rise = ref_clk[ch] && !ref_prev[ch];
            g_rise = gen_clk[ch] && !gen_prev[ch];
            valid_m[ch] = 1'b0;
            if (reset) begin
                pd_state[ch] = 0;
                pd_cnt[ch]   = 0;
                err_m[ch]    = 0;
                lock_m[ch]   = 0;
                ref_prev[ch] = 1'b0;
                gen_prev[ch] = 1'b0;
            end else begin
                if (pd_state[ch] == 0) begin
                    if (r_rise && g_rise) begin
                        err_m[ch]   = 0;
                        valid_m[ch] = 1'b1;
                    end else if (r_rise || g_rise) begin
                        pd_state[ch] = r_rise ? 1 : 2;
                        pd_cnt[ch]   = 1;
                    end
                end else if ((pd_state[ch] == 1 && g_rise) || (pd_state[ch] == 2 && r_rise)) begin
                    err_m[ch]    = (pd_state[ch] == 1) ? pd_cnt[ch] : -pd_cnt[ch];
                    valid_m[ch]  = 1'b1;
                    pd_state[ch] = 0;
                end else if (pd_cnt[ch] < ERR_MAX) begin
                    pd_cnt[ch] = pd_cnt[ch] + 1;
                end
                if (valid_m[ch]) begin
                    if (err_m[ch] > `ADPLL_LOCK_TOL || err_m[ch] < -`ADPLL_LOCK_TOL) begin
                        lock_m[ch]       = 0;
                        out_tol_seen[ch] = 1'b1;
                    end else if (lock_m[ch] < `ADPLL_LOCK_CNT) begin
                        lock_m[ch] = lock_m[ch] + 1;
                    end
                end
                ref_prev[ch] = ref_clk[ch];
                gen_prev[ch] = gen_clk[ch];
            end
        end
    end

    initial begin
        int ref_edges [NCH];
        int gen_edges [NCH];
        bit ref_last [NCH];
        bit gen_last [NCH];
        int waited;
        void'($urandom(16));
        fpga_clk = 1'b0;
        reset    = 1'b1;
        sel      = '0;
        for (int ch = 0; ch < NCH; ch++) begin
            ref_k[ch] = near_bias_word();
        end
        repeat (15) @(posedge fpga_clk);
        @(negedge fpga_clk);
        check_equal(ref_clk, 0, "ref_clk_o in reset");
        check_equal(gen_clk, 0, "gen_clk_o in reset");
        check_equal(error, 0, "error_o in reset");
        check_equal(locked, 0, "locked_o in reset");
        check_equal(digit, 8'hFE, "digit_o in reset");
        check_equal(segment, expected_segment(0, 0), "segment_o in reset");
        @(posedge fpga_clk);
        #2 reset = 1'b0;

        for (int s = 0; s < NCH; s++) begin
            sel = adpll_pkg::ch_sel_t'(s);
            repeat (SWEEP_CYC) @(posedge fpga_clk);
            #2;
            if (s == 1) begin
                for (int ch = 0; ch < NCH; ch++) begin
                    ref_k[ch] = near_bias_word();   // retune mid-run
                end
            end
        end
        repeat (SETTLE_CYC) @(posedge fpga_clk);

        @(negedge fpga_clk);
        for (int ch = 0; ch < NCH; ch++) begin
            ref_edges[ch] = 0;
            gen_edges[ch] = 0;
            ref_last[ch]  = ref_clk[ch];
            gen_last[ch]  = gen_clk[ch];
        end
        repeat (WINDOW_CYC) begin
            @(negedge fpga_clk);
            for (int ch = 0; ch < NCH; ch++) begin
                ref_edges[ch] += (ref_clk[ch] && !ref_last[ch]) ? 1 : 0;
                gen_edges[ch] += (gen_clk[ch] && !gen_last[ch]) ? 1 : 0;
                ref_last[ch]  = ref_clk[ch];
                gen_last[ch]  = gen_clk[ch];
            end
        end
        for (int ch = 0; ch < NCH; ch++) begin
            if (ref_edges[ch] - gen_edges[ch] > 1 || gen_edges[ch] - ref_edges[ch] > 1) begin
                stop_with_failure($sformatf("channel %0d is not frequency locked: %0d %s %0d",
                                            ch, ref_edges[ch], "reference edges against",
                                            gen_edges[ch]));
            end
        end

        for (int ch = 0; ch < NCH; ch++) begin
            @(posedge fpga_clk);
            #2 sel = adpll_pkg::ch_sel_t'(ch);
            repeat (2) @(negedge fpga_clk);      // let the display take the new channel
            waited = 0;
            while (!locked && waited < LOCK_WAIT) begin
                @(negedge fpga_clk);
                waited++;
            end
            if (!locked) begin
                stop_with_failure($sformatf("channel %0d never reported lock", ch));
            end
        end

        @(posedge fpga_clk);
        #2;
        sel             = '0;
        out_tol_seen[0] = 1'b0;
        ref_k[0]        = adpll_pkg::tune_word_t'(2 * `ADPLL_BIAS);
        repeat (2) @(negedge fpga_clk);
        waited = 0;
        while (locked && waited < FAR_WAIT) begin
            @(negedge fpga_clk);
            waited++;
        end
        if (locked) begin
            stop_with_failure("channel 0 kept its lock flag with a far tuning word");
        end
        @(posedge fpga_clk);
        #2;
        if (!out_tol_seen[0]) begin
            stop_with_failure("channel 0 model never saw an error outside tolerance");
        end else if (digit_seen != 4'hF) begin
            stop_with_failure("the display scan did not reach all four digits");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== sim.f ====
+incdir+include
verilog/adpll_pkg.sv
verilog/ref_osc_bank.sv
verilog/phase_detector.sv
verilog/loop_filter.sv
verilog/adpll_channel.sv
verilog/error_display.sv
verilog/adpll_bank_top.sv
sim/adpll_bank_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ADPLL bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module adpll_bank_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vadpll_bank_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
